// File: Bender.yml
package:
  name: spi_master

sources:
  - include_dirs:
      - design
    files:
      - design/spi_pkg.sv
      - design/spi_xfer_if.sv
      - design/spi_cmd_decode.sv
      - design/spi_shift_engine.sv
      - design/spi_read_result.sv
      - design/spi_master.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/spi_slave_model.sv
      - tb/tb_spi_master.sv

// File: design/spi_cmd_decode.sv
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_cmd_decode (
  input  logic              clk,
  input  logic              rst_n,
  input  spi_pkg::spi_cmd_t cmd_in,
  input  logic              cmd_vld,
  output logic              cmd_rdy,
  spi_xfer_if.decode        xfer,
  output logic              deliver
);
  import spi_pkg::*;

  localparam spi_bitcnt_t WRITE_BITS = spi_bitcnt_t'(`SPI_CMD_WIDTH);
  localparam spi_bitcnt_t READ_BITS  = spi_bitcnt_t'(`SPI_CMD_WIDTH + `SPI_READ_WIDTH);

  spi_cmd_t cmd_q;
  spi_dir_e dir_q;
  logic     accept;

  assign accept = cmd_vld && cmd_rdy;

  assign xfer.tx_word    = cmd_q;
  assign xfer.total_bits = (dir_q == DIR_WRITE) ? WRITE_BITS : READ_BITS;

  // Command word held for the engine to load on start
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q <= cmd_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cmd_rdy    <= 1'b1;
      dir_q      <= DIR_WRITE;
      xfer.start <= 1'b0;
      deliver    <= 1'b0;
    end
    else
    begin
      xfer.start <= accept;   // One cycle after the handshake
      if (accept)
      begin
        cmd_rdy <= 1'b0;
        dir_q   <= spi_dir_e'(cmd_in[`SPI_RW_BIT]);
      end
      else if (xfer.done)
      begin
        cmd_rdy <= 1'b1;
      end
      // Only reads hand a byte back
      deliver <= xfer.done && (dir_q == DIR_READ);
    end
  end

  // Engine must be idle whenever a transfer is launched
  a_start_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    xfer.start |-> !xfer.busy
  ) else $error("start raised while engine busy");

  // Held command word must be a read whenever a byte is delivered
  a_no_write_deliver: assert property (
    @(posedge clk) disable iff (!rst_n)
    deliver |-> (cmd_q[`SPI_RW_BIT] == DIR_READ)
  ) else $error("deliver after a write transfer");

endmodule

// File: design/spi_macros.svh
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// Command word and returned byte
`define SPI_CMD_WIDTH  12
`define SPI_READ_WIDTH 8

// Index of the write/read flag in the command
`define SPI_RW_BIT     11

// System clocks per sclk half period
`define SPI_SCLK_HALF  2

`endif

// File: design/spi_master.sv
`timescale 1ns/1ps

module spi_master (
  input  logic               clk,
  input  logic               rst_n,
  input  spi_pkg::spi_cmd_t  cmd_in,
  input  logic               cmd_vld,
  output logic               cmd_rdy,
  output logic               sclk,
  output logic               cs,
  output logic               mosi,
  input  logic               miso,
  output logic               read_vld,
  output spi_pkg::spi_data_t read_data
);

  logic deliver;

  spi_xfer_if xfer_if ();
  spi_rx_if   rx_if ();

  // Command handshake and transfer launch
  spi_cmd_decode i_decode (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_in  (cmd_in),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .xfer    (xfer_if.decode),
    .deliver (deliver)
  );

  spi_shift_engine i_engine (
    .clk   (clk),
    .rst_n (rst_n),
    .xfer  (xfer_if.engine),
    .rx    (rx_if.engine),
    .sclk  (sclk),
    .cs    (cs),
    .mosi  (mosi),
    .miso  (miso)
  );

  // Read byte assembly
  spi_read_result i_result (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx_if.result),
    .deliver   (deliver),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

endmodule

// File: design/spi_pkg.sv
`include "spi_macros.svh"

package spi_pkg;

  typedef logic [`SPI_CMD_WIDTH-1:0] spi_cmd_t;

  typedef logic [`SPI_READ_WIDTH-1:0] spi_data_t;

  // Direction taken from the command flag bit
  typedef enum logic {
    DIR_READ  = 1'b0,
    DIR_WRITE = 1'b1
  } spi_dir_e;

  // Wide enough for a full read transfer, 20 bits
  typedef logic [$clog2(`SPI_CMD_WIDTH + `SPI_READ_WIDTH + 1)-1:0] spi_bitcnt_t;

  typedef enum logic [2:0] {
    IDLE,
    SETUP,     // cs low, first low half of bit 11
    SHIFT_LO,
    SHIFT_HI,
    HOLD       // sclk back low before cs rises
  } spi_eng_state_e;

endpackage

// File: design/spi_read_result.sv
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_read_result (
  input  logic               clk,
  input  logic               rst_n,
  spi_rx_if.result           rx,
  input  logic               deliver,
  output logic               read_vld,
  output spi_pkg::spi_data_t read_data
);
  import spi_pkg::*;

  // Latest samples, oldest bit falls off the top
  spi_data_t samples;

  always_ff @(posedge clk)
  begin
    if (rx.sample_vld)
    begin
      samples <= {samples[`SPI_READ_WIDTH-2:0], rx.sample_bit};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      read_vld  <= 1'b0;
      read_data <= '0;
    end
    else
    begin
      read_vld <= deliver;
      if (deliver)
      begin
        read_data <= samples;   // Held until the next read
      end
    end
  end

  a_read_vld_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    read_vld |=> !read_vld
  ) else $error("read_vld longer than one cycle");

endmodule

// File: design/spi_shift_engine.sv
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_shift_engine (
  input  logic       clk,
  input  logic       rst_n,
  spi_xfer_if.engine xfer,
  spi_rx_if.engine   rx,
  output logic       sclk,
  output logic       cs,
  output logic       mosi,
  input  logic       miso
);
  import spi_pkg::*;

  localparam int DIV_W = (`SPI_SCLK_HALF > 1) ? $clog2(`SPI_SCLK_HALF) : 1;

  spi_eng_state_e   state;
  logic [DIV_W-1:0] div_cnt;
  spi_bitcnt_t      bit_cnt;
  spi_bitcnt_t      bits_total;
  spi_cmd_t         tx_shift;
  logic             half_end;
  logic             last_bit;

  assign half_end = (div_cnt == DIV_W'(`SPI_SCLK_HALF - 1));
  assign last_bit = (bit_cnt == spi_bitcnt_t'(bits_total - 1'b1));

  assign xfer.busy = (state != IDLE);

  // Half period divider, restarts on every sclk phase
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt <= '0;
    end
    else if (state == IDLE || half_end)
    begin
      div_cnt <= '0;
    end
    else
    begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Bits still to send, MSB first. Zero fill keeps mosi low in the read phase
  always_ff @(posedge clk)
  begin
    if (state == IDLE && xfer.start)
    begin
      tx_shift   <= {xfer.tx_word[`SPI_CMD_WIDTH-2:0], 1'b0};
      bits_total <= xfer.total_bits;
    end
    else if (state == SHIFT_HI && half_end && !last_bit)
    begin
      tx_shift <= {tx_shift[`SPI_CMD_WIDTH-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= IDLE;
      sclk          <= 1'b0;
      cs            <= 1'b1;
      mosi          <= 1'b0;
      bit_cnt       <= '0;
      xfer.done     <= 1'b0;
      rx.sample_vld <= 1'b0;
      rx.sample_bit <= 1'b0;
    end
    else
    begin
      xfer.done     <= 1'b0;
      rx.sample_vld <= 1'b0;
      case (state)
        IDLE:
        begin
          if (xfer.start)
          begin
            state   <= SETUP;
            cs      <= 1'b0;
            mosi    <= xfer.tx_word[`SPI_CMD_WIDTH-1];   // Bit 11 goes out with cs
            bit_cnt <= '0;
          end
        end
        SETUP, SHIFT_LO:
        begin
          if (half_end)
          begin
            // Rising edge, mid bit
            sclk          <= 1'b1;
            rx.sample_vld <= 1'b1;
            rx.sample_bit <= miso;
            state         <= SHIFT_HI;
          end
        end
        SHIFT_HI:
        begin
          if (half_end)
          begin
            sclk    <= 1'b0;
            bit_cnt <= bit_cnt + 1'b1;
            if (last_bit)
            begin
              mosi  <= 1'b0;
              state <= HOLD;
            end
            else
            begin
              mosi  <= tx_shift[`SPI_CMD_WIDTH-1];   // Change on falling edge
              state <= SHIFT_LO;
            end
          end
        end
        HOLD:
        begin
          if (half_end)
          begin
            cs        <= 1'b1;
            xfer.done <= 1'b1;
            state     <= IDLE;
          end
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  a_cs_low_on_sclk: assert property (
    @(posedge clk) disable iff (!rst_n)
    sclk |-> !cs
  ) else $error("sclk high outside a cs frame");

  // Samples only come from inside a frame
  a_sample_in_frame: assert property (
    @(posedge clk) disable iff (!rst_n)
    rx.sample_vld |-> !cs
  ) else $error("miso sampled while cs high");

endmodule

// File: design/spi_xfer_if.sv
`timescale 1ns/1ps

// Transfer launch and completion between decoder and shift engine
interface spi_xfer_if;
  import spi_pkg::*;

  logic        start;
  spi_cmd_t    tx_word;
  spi_bitcnt_t total_bits;   // 12 for write, 20 for read
  logic        busy;
  logic        done;

  modport decode (output start, output tx_word, output total_bits, input busy, input done);

  modport engine (input start, input tx_word, input total_bits, output busy, output done);

endinterface

// Sampled miso bits, one per rising sclk edge
interface spi_rx_if;

  logic sample_vld;
  logic sample_bit;

  modport engine (output sample_vld, output sample_bit);

  modport result (input sample_vld, input sample_bit);

endinterface

// File: tb.f
+incdir+design
design/spi_pkg.sv
design/spi_xfer_if.sv
design/spi_cmd_decode.sv
design/spi_shift_engine.sv
design/spi_read_result.sv
design/spi_master.sv
tb/spi_slave_model.sv
tb/tb_spi_master.sv

// File: tb/spi_slave_model.sv
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_slave_model (
  input  logic               cs,
  input  logic               sclk,
  input  logic               mosi,
  input  spi_pkg::spi_data_t resp_byte,
  output logic               miso,
  output spi_pkg::spi_cmd_t  cmd_captured,
  output int                 sclk_count,
  output int                 frame_count
);
  import spi_pkg::*;

  spi_cmd_t shift_reg;
  int       rd_idx;
  logic     in_frame;

  initial
  begin
    miso         = 1'b0;
    cmd_captured = '0;
    shift_reg    = '0;
    sclk_count   = 0;
    frame_count  = 0;
    rd_idx       = 0;
    in_frame     = 1'b0;
  end

  always @(negedge cs)
  begin
    in_frame   <= 1'b1;
    sclk_count <= 0;
    rd_idx     <= 0;
  end

  // Command bits only, read phase clocks are just counted
  always @(posedge sclk)
  begin
    if (!cs)
    begin
      if (sclk_count < `SPI_CMD_WIDTH)
      begin
        shift_reg <= {shift_reg[`SPI_CMD_WIDTH-2:0], mosi};
      end
      sclk_count <= sclk_count + 1;
    end
  end

  // Read byte MSB first, once the command is in
  always @(negedge sclk)
  begin
    if (!cs && sclk_count >= `SPI_CMD_WIDTH && shift_reg[`SPI_RW_BIT] == DIR_READ
        && rd_idx < `SPI_READ_WIDTH)
    begin
      miso   <= resp_byte[`SPI_READ_WIDTH-1-rd_idx];
      rd_idx <= rd_idx + 1;
    end
    else
    begin
      miso <= 1'b0;
    end
  end

  always @(posedge cs)
  begin
    if (in_frame)
    begin
      in_frame     <= 1'b0;
      cmd_captured <= shift_reg;
      frame_count  <= frame_count + 1;
      miso         <= 1'b0;
    end
  end

endmodule

// File: tb/tb_spi_master.sv
`timescale 1ns/1ps
`include "spi_macros.svh"

module tb_spi_master;
  import spi_pkg::*;

  localparam int N_RANDOM    = 40;
  localparam int N_DIRECTED  = 4;
  // A read with its idle gap stays well under 100 cycles
  localparam int CYCLE_LIMIT = (N_RANDOM + N_DIRECTED) * 100 + 200;

  logic      clk;
  logic      rst_n;
  spi_cmd_t  cmd_in;
  logic      cmd_vld;
  logic      cmd_rdy;
  logic      sclk;
  logic      cs;
  logic      mosi;
  logic      miso;
  logic      read_vld;
  spi_data_t read_data;

  spi_data_t resp_byte;
  spi_cmd_t  cmd_captured;
  int        sclk_count;
  int        frame_count;

  integer    seed = 32'h7183_121c;
  int        cycle_cnt;
  int        hs_count;
  int        read_count;
  spi_data_t last_read;   // Expected byte of the latest read
  spi_data_t exp_byte;
  spi_data_t read_exp[$];   // Expected bytes of reads in flight
  spi_cmd_t  rnd_cmd;
  int        rnd_gap;

  spi_master i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model i_slave (
    .cs           (cs),
    .sclk         (sclk),
    .mosi         (mosi),
    .resp_byte    (resp_byte),
    .miso         (miso),
    .cmd_captured (cmd_captured),
    .sclk_count   (sclk_count),
    .frame_count  (frame_count)
  );

  always #20 clk = ~clk;

  // Slave answer: low command byte XOR A5, rotated left by one
  function automatic spi_data_t slave_byte(spi_cmd_t cmd);
    spi_data_t x;
    x = cmd[7:0] ^ 8'hA5;
    return {x[6:0], x[7]};
  endfunction

  task automatic stop_run();
    $display("** FAIL **");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_fault(string msg);
    $display("Protocol fault at %0t ns: %s", $time, msg);
    stop_run();
  endtask

  task automatic check_cmd(spi_cmd_t got, spi_cmd_t exp);
    if (got !== exp)
    begin
      $display("ERR %0t ns: slave captured command %h, expected %h", $time, got, exp);
      stop_run();
    end
  endtask

  task automatic check_data(spi_data_t got, spi_data_t exp);
    if (got !== exp)
    begin
      $display("ERR %0t ns: read_data is %h, expected %h", $time, got, exp);
      stop_run();
    end
  endtask

  task automatic check_count(string what, int got, int exp);
    if (got != exp)
    begin
      report_fault($sformatf("%s is %0d instead of %0d", what, got, exp));
    end
  endtask

  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT)
    begin
      $display("Timeout after %0d cycles, a transfer never finished", cycle_cnt);
      stop_run();
    end
  end

  always @(posedge clk)
  begin
    if (rst_n && cmd_vld && cmd_rdy)
    begin
      hs_count++;
    end
  end

  // Every delivered byte against the reference
  always @(negedge clk)
  begin
    if (rst_n && read_vld)
    begin
      if (read_exp.size() == 0)
      begin
        report_fault("read_vld pulsed with no read in flight");
      end
      else
      begin
        exp_byte = read_exp.pop_front();
        check_data(read_data, exp_byte);
        last_read = exp_byte;
        read_count++;
      end
    end
  end

  // One command end to end, optionally pushing a second one while busy
  task automatic run_transfer(spi_cmd_t cmd, int gap, bit hold_other, spi_cmd_t other);
    int        frames_before;
    int        reads_before;
    int        exp_bits;
    bit        is_read;
    repeat (gap) @(negedge clk);
    while (!cmd_rdy) @(negedge clk);
    is_read       = (cmd[`SPI_RW_BIT] == DIR_READ);
    exp_bits      = is_read ? `SPI_CMD_WIDTH + `SPI_READ_WIDTH : `SPI_CMD_WIDTH;
    frames_before = frame_count;
    reads_before  = read_count;
    resp_byte     = slave_byte(cmd);
    cmd_in        = cmd;
    cmd_vld       = 1'b1;
    @(negedge clk);
    if (cmd_rdy)
    begin
      report_fault("cmd_rdy still high after a handshake");
    end
    if (is_read)
    begin
      read_exp.push_back(slave_byte(cmd));
    end
    if (hold_other)
    begin
      cmd_in = other;   // Must be ignored while busy
    end
    else
    begin
      cmd_vld = 1'b0;
    end
    while (!cmd_rdy) @(negedge clk);
    cmd_vld = 1'b0;
    check_count("Frames for one command", frame_count - frames_before, 1);
    check_count("sclk pulses in the frame", sclk_count, exp_bits);
    check_cmd(cmd_captured, cmd);
    if (is_read)
    begin
      while (read_count == reads_before) @(negedge clk);
    end
    repeat (3) @(negedge clk);
    check_count("Frames after settling", frame_count - frames_before, 1);
    check_count("read_vld pulses", read_count - reads_before, is_read ? 1 : 0);
    if (!is_read && read_count > 0)
    begin
      check_data(read_data, last_read);
    end
  endtask

  initial
  begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    cmd_in     = '0;
    cmd_vld    = 1'b0;
    resp_byte  = '0;
    cycle_cnt  = 0;
    hs_count   = 0;
    read_count = 0;
    last_read  = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (cs !== 1'b1 || sclk !== 1'b0 || mosi !== 1'b0 || read_vld !== 1'b0 || cmd_rdy !== 1'b1)
    begin
      report_fault("Outputs are not idle after reset");
    end
    run_transfer(12'hB3C, 0, 1'b0, '0);         // Write
    run_transfer(12'h35A, 2, 1'b0, '0);         // Read
    run_transfer(12'h9E1, 1, 1'b1, 12'h7FF);
    run_transfer(12'h0C3, 1, 1'b1, 12'h8AA);    // Read under back-pressure
    for (int i = 0; i < N_RANDOM; i++)
    begin
      rnd_cmd = spi_cmd_t'($random(seed));
      rnd_gap = $unsigned($random(seed)) % 6;
      run_transfer(rnd_cmd, rnd_gap, 1'b0, '0);
    end
    if (frame_count == hs_count && read_exp.size() == 0)
    begin
      $display("** PASS **");
      $finish;
    end
    else
    begin
      report_fault("Transfer count does not match accepted handshakes");
    end
  end

endmodule
